/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

   localparam int XLEN       = 64;
   localparam int ILEN       = 32;
   localparam int REG_ADDR_W = 5;

   // Major opcodes of the supported subset
   localparam logic [6:0] OP_RTYPE = 7'b0110011;
   localparam logic [6:0] OP_ADDI  = 7'b0010011;
   localparam logic [6:0] OP_LOAD  = 7'b0000011;
   localparam logic [6:0] OP_STORE = 7'b0100011;

   // Main decoder to ALU control
   localparam logic [1:0] ALUOP_ADD   = 2'b00;   // Address calc and addi
   localparam logic [1:0] ALUOP_FUNCT = 2'b10;   // R-type picks the op from funct fields

   typedef enum logic [3:0] {
      ALU_AND = 4'b0000,
      ALU_OR  = 4'b0001,
      ALU_ADD = 4'b0010,
      ALU_SUB = 4'b0110,
      ALU_SLT = 4'b0111
   } alu_ctrl_e;

   typedef logic [XLEN-1:0] xword_t;
   typedef logic [ILEN-1:0] inst_t;

   typedef struct packed {
      logic       reg_write;
      logic       mem_to_reg;   // Writeback takes load data
      logic       mem_read;
      logic       mem_write;
      logic       alu_src;      // Immediate as second operand
      logic [1:0] alu_op;
   } ctrl_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      xword_t                rd1;
      xword_t                rd2;
      xword_t                imm;
      logic [6:0]            funct7;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rs1;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rd;
   } id_ex_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      xword_t                alu_out;
      xword_t                store_data;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rd;
   } ex_mem_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      xword_t                mem_data;
      xword_t                alu_out;
      logic [REG_ADDR_W-1:0] rd;
   } mem_wb_t;

endpackage

`default_nettype wire

/* hdl/sram_ext.sv */
`default_nettype none

module sram_ext
   import rv_pkg::*;
#(
   parameter int  ADDR_W = 10,
   parameter type word_t = xword_t
) (
   input  wire logic   clk,
   input  wire xword_t addr,
   input  wire logic   wen,
   input  wire word_t  wdata,
   output word_t       rdata,
   input  wire xword_t addr_ext,
   input  wire logic   wen_ext,
   input  wire logic   ren_ext,
   input  wire word_t  wdata_ext,
   output word_t       rdata_ext
);

   // Byte offset bits dropped from the address
   localparam int OFFS_W = $clog2($bits(word_t) / 8);

   word_t             mem [2**ADDR_W];
   logic [ADDR_W-1:0] idx;
   logic [ADDR_W-1:0] idx_ext;

   assign idx     = addr[OFFS_W +: ADDR_W];
   assign idx_ext = addr_ext[OFFS_W +: ADDR_W];

   always_ff @(posedge clk) begin
      if (wen) begin
         mem[idx] <= wdata;
      end
      if (wen_ext) begin
         mem[idx_ext] <= wdata_ext;   // Last assignment wins on a clash
      end
   end

   assign rdata     = mem[idx];
   assign rdata_ext = ren_ext ? mem[idx_ext] : '0;

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`default_nettype none

module regfile
   import rv_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire logic [REG_ADDR_W-1:0] raddr_1,
   input  wire logic [REG_ADDR_W-1:0] raddr_2,
   output xword_t                     rdata_1,
   output xword_t                     rdata_2,
   input  wire logic                  wen,
   input  wire logic [REG_ADDR_W-1:0] waddr,
   input  wire xword_t                wdata
);

   xword_t regs [2**REG_ADDR_W];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 2**REG_ADDR_W; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // x0 first, then the value being written back this cycle
   assign rdata_1 = (raddr_1 == '0)              ? '0    :
                    (wen && waddr == raddr_1)    ? wdata : regs[raddr_1];
   assign rdata_2 = (raddr_2 == '0)              ? '0    :
                    (wen && waddr == raddr_2)    ? wdata : regs[raddr_2];

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`default_nettype none

module decode_stage
   import rv_pkg::*;
(
   input  wire inst_t                 inst,
   input  wire xword_t                rdata_1,
   input  wire xword_t                rdata_2,
   input  wire logic                  ex_mem_read,   // Load currently in EX
   input  wire logic [REG_ADDR_W-1:0] ex_rd,
   output logic [REG_ADDR_W-1:0]      raddr_1,
   output logic [REG_ADDR_W-1:0]      raddr_2,
   output id_ex_t                     id_ex,
   output logic                       stall
);

   localparam logic [2:0] F3_ADDI   = 3'b000;
   localparam logic [2:0] F3_DOUBLE = 3'b011;   // ld / sd

   logic [6:0]            opcode;
   logic [2:0]            funct3;
   logic [REG_ADDR_W-1:0] rs1;
   logic [REG_ADDR_W-1:0] rs2;
   logic [REG_ADDR_W-1:0] rd;
   ctrl_t                 ctrl;
   logic                  uses_rs2;
   xword_t                imm;

   assign opcode  = inst[6:0];
   assign rd      = inst[11:7];
   assign funct3  = inst[14:12];
   assign rs1     = inst[19:15];
   assign rs2     = inst[24:20];
   assign raddr_1 = rs1;
   assign raddr_2 = rs2;

   always_comb begin
      ctrl     = '0;
      uses_rs2 = 1'b0;
      case (opcode)
         OP_RTYPE: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = ALUOP_FUNCT;
            uses_rs2       = 1'b1;
         end
         OP_ADDI: begin
            if (funct3 == F3_ADDI) begin
               ctrl.reg_write = 1'b1;
               ctrl.alu_src   = 1'b1;
            end
         end
         OP_LOAD: begin
            if (funct3 == F3_DOUBLE) begin
               ctrl.reg_write  = 1'b1;
               ctrl.mem_to_reg = 1'b1;
               ctrl.mem_read   = 1'b1;
               ctrl.alu_src    = 1'b1;
            end
         end
         OP_STORE: begin
            if (funct3 == F3_DOUBLE) begin
               ctrl.mem_write = 1'b1;
               ctrl.alu_src   = 1'b1;
               uses_rs2       = 1'b1;   // Store data
            end
         end
         default: ;   // Anything else is a bubble
      endcase
   end

   // S-type splits the offset around rd
   assign imm = (opcode == OP_STORE) ?
                {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]} :
                {{(XLEN-12){inst[31]}}, inst[31:20]};

   // Consumer of a load waits one cycle so WB forwarding can cover it
   assign stall = ex_mem_read && ex_rd != '0 && ctrl != '0 &&
                  (ex_rd == rs1 || (uses_rs2 && ex_rd == rs2));

   assign id_ex = '{ctrl:   stall ? ctrl_t'('0) : ctrl,
                    rd1:    rdata_1,
                    rd2:    rdata_2,
                    imm:    imm,
                    funct7: inst[31:25],
                    funct3: funct3,
                    rs1:    rs1,
                    rs2:    rs2,
                    rd:     rd};

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`default_nettype none

module execute_stage
   import rv_pkg::*;
(
   input  wire id_ex_t                id_ex,
   input  wire logic [REG_ADDR_W-1:0] mem_fwd_rd,
   input  wire logic                  mem_fwd_write,
   input  wire xword_t                mem_fwd_data,
   input  wire logic [REG_ADDR_W-1:0] wb_fwd_rd,
   input  wire logic                  wb_fwd_write,
   input  wire xword_t                wb_fwd_data,
   output ex_mem_t                    ex_mem
);

   xword_t    op_a;
   xword_t    rs2_val;
   xword_t    op_b;
   xword_t    alu_out;
   alu_ctrl_e alu_ctrl;

   // Newest producer wins and x0 is never forwarded
   function automatic xword_t forward(input logic [REG_ADDR_W-1:0] rs,
                                      input xword_t                reg_val);
      if (rs == '0) begin
         return reg_val;
      end
      if (mem_fwd_write && mem_fwd_rd == rs) begin
         return mem_fwd_data;
      end
      if (wb_fwd_write && wb_fwd_rd == rs) begin
         return wb_fwd_data;
      end
      return reg_val;
   endfunction

   always_comb begin
      op_a    = forward(id_ex.rs1, id_ex.rd1);
      rs2_val = forward(id_ex.rs2, id_ex.rd2);
   end

   assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : rs2_val;

   always_comb begin
      alu_ctrl = ALU_ADD;
      if (id_ex.ctrl.alu_op == ALUOP_FUNCT) begin
         case (id_ex.funct3)
            3'b000:  alu_ctrl = id_ex.funct7[5] ? ALU_SUB : ALU_ADD;
            3'b010:  alu_ctrl = ALU_SLT;
            3'b110:  alu_ctrl = ALU_OR;
            3'b111:  alu_ctrl = ALU_AND;
            default: alu_ctrl = ALU_ADD;
         endcase
      end
   end

   always_comb begin
      case (alu_ctrl)
         ALU_SUB: alu_out = op_a - op_b;
         ALU_AND: alu_out = op_a & op_b;
         ALU_OR:  alu_out = op_a | op_b;
         ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         default: alu_out = op_a + op_b;
      endcase
   end

   assign ex_mem = '{ctrl:       id_ex.ctrl,
                     alu_out:    alu_out,
                     store_data: rs2_val,   // Already forwarded
                     rs2:        id_ex.rs2,
                     rd:         id_ex.rd};

endmodule

`default_nettype wire

/* hdl/cpu.sv */
`default_nettype none

module cpu
   import rv_pkg::*;
#(
   parameter int IMEM_ADDR_W = 9,
   parameter int DMEM_ADDR_W = 10
) (
   input  wire logic   clk,
   input  wire logic   rst_n,
   input  wire logic   enable,
   input  wire xword_t addr_ext,
   input  wire logic   wen_ext,
   input  wire logic   ren_ext,
   input  wire inst_t  wdata_ext,
   output inst_t       rdata_ext,
   input  wire xword_t addr_ext_2,
   input  wire logic   wen_ext_2,
   input  wire logic   ren_ext_2,
   input  wire xword_t wdata_ext_2,
   output xword_t      rdata_ext_2
);

   xword_t                pc;
   inst_t                 imem_rdata;
   inst_t                 if_id_inst;
   logic                  stall;
   logic                  advance;
   logic [REG_ADDR_W-1:0] raddr_1;
   logic [REG_ADDR_W-1:0] raddr_2;
   xword_t                rf_rdata_1;
   xword_t                rf_rdata_2;
   id_ex_t                id_ex_d;
   id_ex_t                id_ex_q;
   ex_mem_t               ex_mem_d;
   ex_mem_t               ex_mem_q;
   mem_wb_t               mem_wb_d;
   mem_wb_t               mem_wb_q;
   xword_t                dmem_rdata;
   xword_t                wb_data;

   assign advance = enable && !stall;   // Front end holds on a load-use stall

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (advance) begin
         pc <= pc + 4;
      end
   end

   sram_ext #(
      .ADDR_W (IMEM_ADDR_W),
      .word_t (inst_t)
   ) imem (
      .clk       (clk),
      .addr      (pc),
      .wen       (1'b0),
      .wdata     ('0),
      .rdata     (imem_rdata),
      .addr_ext  (addr_ext),
      .wen_ext   (wen_ext),
      .ren_ext   (ren_ext),
      .wdata_ext (wdata_ext),
      .rdata_ext (rdata_ext)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         if_id_inst <= '0;   // Opcode 0 decodes as a bubble
      end else if (advance) begin
         if_id_inst <= imem_rdata;
      end
   end

   regfile u_regfile (
      .clk     (clk),
      .rst_n   (rst_n),
      .raddr_1 (raddr_1),
      .raddr_2 (raddr_2),
      .rdata_1 (rf_rdata_1),
      .rdata_2 (rf_rdata_2),
      .wen     (mem_wb_q.ctrl.reg_write && enable),
      .waddr   (mem_wb_q.rd),
      .wdata   (wb_data)
   );

   decode_stage u_decode (
      .inst        (if_id_inst),
      .rdata_1     (rf_rdata_1),
      .rdata_2     (rf_rdata_2),
      .ex_mem_read (id_ex_q.ctrl.mem_read),
      .ex_rd       (id_ex_q.rd),
      .raddr_1     (raddr_1),
      .raddr_2     (raddr_2),
      .id_ex       (id_ex_d),
      .stall       (stall)
   );

   // Back end keeps moving during a stall with the bubble in id_ex_d
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_ex_q  <= '0;
         ex_mem_q <= '0;
         mem_wb_q <= '0;
      end else if (enable) begin
         id_ex_q  <= id_ex_d;
         ex_mem_q <= ex_mem_d;
         mem_wb_q <= mem_wb_d;
      end
   end

   execute_stage u_execute (
      .id_ex         (id_ex_q),
      .mem_fwd_rd    (ex_mem_q.rd),
      .mem_fwd_write (ex_mem_q.ctrl.reg_write),
      .mem_fwd_data  (ex_mem_q.alu_out),
      .wb_fwd_rd     (mem_wb_q.rd),
      .wb_fwd_write  (mem_wb_q.ctrl.reg_write),
      .wb_fwd_data   (wb_data),
      .ex_mem        (ex_mem_d)
   );

   sram_ext #(
      .ADDR_W (DMEM_ADDR_W),
      .word_t (xword_t)
   ) dmem (
      .clk       (clk),
      .addr      (ex_mem_q.alu_out),
      .wen       (ex_mem_q.ctrl.mem_write && enable),
      .wdata     (ex_mem_q.store_data),
      .rdata     (dmem_rdata),
      .addr_ext  (addr_ext_2),
      .wen_ext   (wen_ext_2),
      .ren_ext   (ren_ext_2),
      .wdata_ext (wdata_ext_2),
      .rdata_ext (rdata_ext_2)
   );

   assign mem_wb_d = '{ctrl:     ex_mem_q.ctrl,
                       mem_data: dmem_rdata,
                       alu_out:  ex_mem_q.alu_out,
                       rd:       ex_mem_q.rd};

   assign wb_data = mem_wb_q.ctrl.mem_to_reg ? mem_wb_q.mem_data : mem_wb_q.alu_out;

endmodule

`default_nettype wire

/* sim/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Operation kinds of a generated program
localparam int K_ADD  = 0;
localparam int K_SUB  = 1;
localparam int K_AND  = 2;
localparam int K_OR   = 3;
localparam int K_SLT  = 4;
localparam int K_ADDI = 5;
localparam int K_LD   = 6;
localparam int K_SD   = 7;

localparam inst_t NOP_INST = {12'd0, 5'd0, 3'b000, 5'd0, OP_ADDI};   // addi x0, x0, 0

int          op_cnt;
int          body_len;   // Ops before the register dump
int          op_kind [IMEM_WORDS];
logic [4:0]  op_rd   [IMEM_WORDS];
logic [4:0]  op_rs1  [IMEM_WORDS];
logic [4:0]  op_rs2  [IMEM_WORDS];
logic [11:0] op_imm  [IMEM_WORDS];
inst_t       prog    [IMEM_WORDS];
xword_t      model_regs [32];
xword_t      model_mem  [DMEM_WORDS];

function automatic inst_t encode(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                                 input logic [4:0] rs2, input logic [11:0] imm);
   case (kind)
      K_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, OP_RTYPE};
      K_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, OP_RTYPE};
      K_AND:   return {7'b0000000, rs2, rs1, 3'b111, rd, OP_RTYPE};
      K_OR:    return {7'b0000000, rs2, rs1, 3'b110, rd, OP_RTYPE};
      K_SLT:   return {7'b0000000, rs2, rs1, 3'b010, rd, OP_RTYPE};
      K_ADDI:  return {imm, rs1, 3'b000, rd, OP_ADDI};
      K_LD:    return {imm, rs1, 3'b011, rd, OP_LOAD};
      default: return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OP_STORE};
   endcase
endfunction

task automatic add_op(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [4:0] rs2, input logic [11:0] imm);
   op_kind[op_cnt] = kind;
   op_rd[op_cnt]   = rd;
   op_rs1[op_cnt]  = rs1;
   op_rs2[op_cnt]  = rs2;
   op_imm[op_cnt]  = imm;
   prog[op_cnt]    = encode(kind, rd, rs1, rs2, imm);
   op_cnt++;
endtask

function automatic int rand_below(input int n);
   return int'($unsigned($random(seed)) % n);
endfunction

function automatic logic [4:0] rand_reg();   // Never x0
   return 5'(rand_below(31) + 1);
endfunction

function automatic logic [4:0] rand_any_reg();
   return 5'(rand_below(32));
endfunction

function automatic logic [11:0] rand_imm();
   return 12'($random(seed));
endfunction

function automatic logic [11:0] rand_offset();   // Word 0..255 off x0
   return 12'(8 * rand_below(CHECK_WORDS));
endfunction

task automatic init_registers();
   int r;
   for (r = 1; r < 32; r++) begin
      add_op(K_ADDI, 5'(r), 5'd0, 5'd0, rand_imm());
   end
endtask

task automatic random_alu_body(input int n);
   int i;
   for (i = 0; i < n; i++) begin
      add_op(rand_below(6), rand_any_reg(), rand_any_reg(), rand_any_reg(), rand_imm());
   end
endtask

// Each op reads one of the last three results, so MEM, WB and the regfile bypass all see use
task automatic dependent_chains(input int n);
   logic [4:0] hist [3];
   logic [4:0] rd;
   int         i;
   hist[0] = 5'd1;
   hist[1] = 5'd2;
   hist[2] = 5'd3;
   for (i = 0; i < n; i++) begin
      rd = rand_reg();
      add_op(rand_below(6), rd, hist[rand_below(3)], hist[rand_below(3)], rand_imm());
      hist[2] = hist[1];
      hist[1] = hist[0];
      hist[0] = rd;
   end
endtask

task automatic load_store_body(input int groups);
   logic [4:0] rd;
   int         g;
   for (g = 0; g < groups; g++) begin
      rd = rand_reg();
      case (rand_below(4))
         0: begin
            add_op(K_LD, rd, 5'd0, 5'd0, rand_offset());
            case (rand_below(3))   // Consumer right behind the load
               0:       add_op(rand_below(6), rand_any_reg(), rd, rand_any_reg(), rand_imm());
               1:       add_op(rand_below(5), rand_any_reg(), rand_any_reg(), rd, 12'd0);
               default: add_op(K_SD, 5'd0, 5'd0, rd, rand_offset());
            endcase
         end
         1: begin
            add_op(rand_below(6), rd, rand_any_reg(), rand_any_reg(), rand_imm());
            add_op(K_SD, 5'd0, 5'd0, rd, rand_offset());   // Store of a fresh result
         end
         2:       add_op(K_LD, rd, 5'd0, 5'd0, rand_offset());
         default: add_op(rand_below(6), rd, rand_any_reg(), rand_any_reg(), rand_imm());
      endcase
   end
endtask

// x31 is parked in word 1023, then serves as base 4096 for words 512..542
task automatic append_dump();
   int r;
   add_op(K_SD, 5'd0, 5'd0, 5'd31, 12'hff8);
   add_op(K_ADDI, 5'd31, 5'd0, 5'd0, 12'd2047);
   add_op(K_ADDI, 5'd31, 5'd31, 5'd0, 12'd2047);
   add_op(K_ADDI, 5'd31, 5'd31, 5'd0, 12'd2);
   for (r = 1; r < 31; r++) begin
      add_op(K_SD, 5'd0, 5'd31, 5'(r), 12'((r - 1) * 8));
   end
   add_op(K_LD, 5'd1, 5'd0, 5'd0, 12'hff8);
   add_op(K_SD, 5'd0, 5'd31, 5'd1, 12'd240);
endtask

// Sequential reference that runs one op at a time
task automatic run_model();
   xword_t                 a;
   xword_t                 b;
   xword_t                 imm;
   xword_t                 addr;
   xword_t                 res;
   logic [DMEM_ADDR_W-1:0] idx;
   int                     i;
   for (i = 0; i < body_len; i++) begin
      a    = model_regs[op_rs1[i]];
      b    = model_regs[op_rs2[i]];
      imm  = {{(XLEN-12){op_imm[i][11]}}, op_imm[i]};
      addr = a + imm;
      idx  = addr[DMEM_ADDR_W+2:3];
      res  = '0;
      case (op_kind[i])
         K_ADD:   res = a + b;
         K_SUB:   res = a - b;
         K_AND:   res = a & b;
         K_OR:    res = a | b;
         K_SLT:   res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
         K_ADDI:  res = a + imm;
         K_LD:    res = model_mem[idx];
         default: model_mem[idx] = b;
      endcase
      if (op_kind[i] != K_SD && op_rd[i] != '0) begin
         model_regs[op_rd[i]] = res;
      end
   end
endtask

`endif

/* sim/tb_cpu.sv */
`default_nettype none

module tb_cpu
   import rv_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int IMEM_ADDR_W = 9;
   localparam int DMEM_ADDR_W = 10;
   localparam int IMEM_WORDS  = 2**IMEM_ADDR_W;
   localparam int DMEM_WORDS  = 2**DMEM_ADDR_W;
   localparam int DUMP_BASE   = 512;   // x1..x31 land here
   localparam int CHECK_WORDS = 256;   // Data words used by ld and sd
   // One cycle per side port access plus a run shorter than the imem size
   localparam int MEM_TEST_CYCLES  = 2 * (IMEM_WORDS + DMEM_WORDS) + 64;
   localparam int PROG_TEST_CYCLES = 2 * IMEM_WORDS + 2 * (CHECK_WORDS + 31) + 64;
   localparam int WATCHDOG_NS      = 2 * 4 * (MEM_TEST_CYCLES + 3 * PROG_TEST_CYCLES);

   logic   clk;
   logic   rst_n;
   logic   enable;
   xword_t addr_ext;
   logic   wen_ext;
   logic   ren_ext;
   inst_t  wdata_ext;
   inst_t  rdata_ext;
   xword_t addr_ext_2;
   logic   wen_ext_2;
   logic   ren_ext_2;
   xword_t wdata_ext_2;
   xword_t rdata_ext_2;

   int     seed = 20820;
   int     test_errors;
   int     total_errors;
   int     tests_run;
   int     tests_failed;
   xword_t expect_words [DMEM_WORDS];

   `include "tb_program.svh"

   cpu #(
      .IMEM_ADDR_W (IMEM_ADDR_W),
      .DMEM_ADDR_W (DMEM_ADDR_W)
   ) UUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .enable      (enable),
      .addr_ext    (addr_ext),
      .wen_ext     (wen_ext),
      .ren_ext     (ren_ext),
      .wdata_ext   (wdata_ext),
      .rdata_ext   (rdata_ext),
      .addr_ext_2  (addr_ext_2),
      .wen_ext_2   (wen_ext_2),
      .ren_ext_2   (ren_ext_2),
      .wdata_ext_2 (wdata_ext_2),
      .rdata_ext_2 (rdata_ext_2)
   );

   always #2 clk = ~clk;

   task automatic check_value(input string name, input xword_t actual, input xword_t expected);
      if (actual !== expected) begin
         $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
         test_errors++;
      end
   endtask

   task automatic reset_dut();
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
   endtask

   // Write lands on the following rising edge
   task automatic write_imem(input int idx, input inst_t data);
      @(posedge clk);
      #1;
      addr_ext  = xword_t'(idx) << 2;
      wdata_ext = data;
      wen_ext   = 1'b1;
   endtask

   task automatic write_dmem(input int idx, input xword_t data);
      @(posedge clk);
      #1;
      addr_ext_2  = xword_t'(idx) << 3;
      wdata_ext_2 = data;
      wen_ext_2   = 1'b1;
   endtask

   task automatic end_writes();
      @(posedge clk);
      #1;
      wen_ext   = 1'b0;
      wen_ext_2 = 1'b0;
   endtask

   task automatic read_imem(input int idx, input logic ren, output inst_t data);
      @(posedge clk);
      #1;
      addr_ext = xword_t'(idx) << 2;
      ren_ext  = ren;
      #1;
      data = rdata_ext;
   endtask

   task automatic read_dmem(input int idx, input logic ren, output xword_t data);
      @(posedge clk);
      #1;
      addr_ext_2 = xword_t'(idx) << 3;
      ren_ext_2  = ren;
      #1;
      data = rdata_ext_2;
   endtask

   task automatic run_core(input int cycles);
      @(posedge clk);
      #1;
      enable = 1'b1;
      repeat (cycles) @(posedge clk);
      #1;
      enable = 1'b0;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      total_errors += test_errors;
      if (test_errors == 0) begin
         $display("Test %s: passed", name);
      end else begin
         tests_failed++;
         $display("Test %s: failed with %0d mismatches", name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic imem_port_test();
      inst_t got;
      int    i;
      for (i = 0; i < IMEM_WORDS; i++) begin
         expect_words[i] = xword_t'(inst_t'($random(seed)));
         write_imem(i, inst_t'(expect_words[i]));
      end
      end_writes();
      for (i = 0; i < IMEM_WORDS; i++) begin
         read_imem(i, 1'b1, got);
         check_value("rdata_ext", xword_t'(got), expect_words[i]);
      end
      for (i = 0; i < 16; i++) begin
         read_imem(rand_below(IMEM_WORDS), 1'b0, got);   // Read strobe low
         check_value("rdata_ext", xword_t'(got), '0);
      end
      finish_test("imem_side_port");
   endtask

   task automatic dmem_port_test();
      xword_t got;
      int     i;
      for (i = 0; i < DMEM_WORDS; i++) begin
         expect_words[i] = {$random(seed), $random(seed)};
         write_dmem(i, expect_words[i]);
      end
      end_writes();
      for (i = 0; i < DMEM_WORDS; i++) begin
         read_dmem(i, 1'b1, got);
         check_value("rdata_ext_2", got, expect_words[i]);
      end
      for (i = 0; i < 16; i++) begin
         read_dmem(rand_below(DMEM_WORDS), 1'b0, got);
         check_value("rdata_ext_2", got, '0);
      end
      finish_test("dmem_side_port");
   endtask

   // kind 0 ALU mix, 1 dependent chains, 2 loads and stores
   task automatic program_test(input string name, input int kind);
      xword_t got;
      int     i;
      int     run_cycles;
      op_cnt = 0;
      for (i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end
      for (i = 0; i < CHECK_WORDS; i++) begin
         model_mem[i] = {$random(seed), $random(seed)};
         write_dmem(i, model_mem[i]);
      end
      for (i = DUMP_BASE; i < DUMP_BASE + 31; i++) begin
         write_dmem(i, '0);   // Clear last dump
      end
      end_writes();
      init_registers();
      case (kind)
         0:       random_alu_body(80);
         1:       dependent_chains(80);
         default: load_store_body(40);
      endcase
      body_len = op_cnt;
      append_dump();
      run_cycles = 2 * op_cnt + 20;
      for (i = 0; i < IMEM_WORDS; i++) begin
         write_imem(i, (i < op_cnt) ? prog[i] : NOP_INST);
      end
      end_writes();
      reset_dut();
      run_model();
      run_core(run_cycles);
      for (i = 1; i < 32; i++) begin
         read_dmem(DUMP_BASE + i - 1, 1'b1, got);
         check_value($sformatf("rdata_ext_2 x%0d", i), got, model_regs[i]);
      end
      if (kind == 2) begin
         for (i = 0; i < CHECK_WORDS; i++) begin
            read_dmem(i, 1'b1, got);
            check_value($sformatf("rdata_ext_2 word %0d", i), got, model_mem[i]);
         end
      end
      finish_test(name);
   endtask

   initial begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      enable       = 1'b0;
      addr_ext     = '0;
      wen_ext      = 1'b0;
      ren_ext      = 1'b0;
      wdata_ext    = '0;
      addr_ext_2   = '0;
      wen_ext_2    = 1'b0;
      ren_ext_2    = 1'b0;
      wdata_ext_2  = '0;
      test_errors  = 0;
      total_errors = 0;
      tests_run    = 0;
      tests_failed = 0;
      reset_dut();
      imem_port_test();
      dmem_port_test();
      program_test("random_alu", 0);
      program_test("dependent_chains", 1);
      program_test("load_store", 2);
      $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed,
               total_errors);
      if (total_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+sim
hdl/rv_pkg.sv
hdl/sram_ext.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/cpu.sv
sim/tb_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile tb_cpu with Verilator and run it, failing when the log holds the fail message
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_cpu -f vlog.f --Mdir obj_dir -o tb_cpu_sim
./obj_dir/tb_cpu_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi
echo "Simulation passed"
